// File: hdl/fetch_macros.svh
// Fetch front end sizes
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Virtual and physical address width
`define ADDR_SIZE 32

// One cache line holds four 32-bit words
`define LINE_BITS 128

// Direct-mapped cache depth
`define ICACHE_LINES 16

// Mapped 4 KB pages, any page number at or above faults
`define MEM_PAGES 4

// First fetch address out of reset
`define RESET_PC 32'h0000_0000

`endif

// File: hdl/fetch_pkg.sv
// Fetch address types
`include "fetch_macros.svh"

package fetch_pkg;

    // Page offset and page number split
    localparam int IDX_BITS = 12;
    localparam int VPN_BITS = `ADDR_SIZE - IDX_BITS;

    // Line address drops word select and byte offset
    localparam int LINE_ADDR_BITS = `ADDR_SIZE - 4;

    // One fetch address seen two ways
    typedef union packed {
        // Page view for the cache request and fault check
        struct packed {
            logic [VPN_BITS-1:0] vpn;
            logic [IDX_BITS-1:0] idx;
        } page_view;
        // Line view for buffer compare and cache index
        struct packed {
            logic [LINE_ADDR_BITS-1:0] line;
            logic [1:0]                word;
            logic [1:0]                byte_off;
        } line_view;
    } fetch_addr_u;

endpackage

// File: hdl/fetch_if.sv
// Fetch and cache request interfaces
`include "fetch_macros.svh"

// Fetch control to line buffer
interface fetch_if;
    import fetch_pkg::*;

    logic        req_valid;
    fetch_addr_u vaddr;
    logic        inval_fetch;
    logic        invalidate_buffer;
    logic        invalidate_icache;
    logic        resp_valid;
    logic [31:0] resp_data;
    logic        resp_fault;

    // Level-held request, response may come in the same cycle
    modport ctrl (
        output req_valid, vaddr, inval_fetch, invalidate_buffer, invalidate_icache,
        input  resp_valid, resp_data, resp_fault
    );
    modport lbuf (
        input  req_valid, vaddr, inval_fetch, invalidate_buffer, invalidate_icache,
        output resp_valid, resp_data, resp_fault
    );
endinterface

// Line buffer to instruction cache
interface icache_if;
    import fetch_pkg::*;

    logic                  req_valid;
    logic                  req_ready;
    logic [VPN_BITS-1:0]   vpn;
    logic [IDX_BITS-1:0]   idx;
    logic                  kill;
    logic                  invalidate;
    logic                  resp_valid;
    fetch_addr_u           resp_vaddr;
    logic [`LINE_BITS-1:0] resp_line;
    logic                  resp_xcpt;

    modport req (
        output req_valid, vpn, idx, kill, invalidate,
        input  req_ready, resp_valid, resp_vaddr, resp_line, resp_xcpt
    );
    modport rsp (
        input  req_valid, vpn, idx, kill, invalidate,
        output req_ready, resp_valid, resp_vaddr, resp_line, resp_xcpt
    );
endinterface

// File: hdl/fetch_ctrl.sv
// Program counter sequencer
`include "fetch_macros.svh"

module fetch_ctrl (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic                    redirect_valid_i,
    input  fetch_pkg::fetch_addr_u  redirect_pc_i,
    input  logic                    flush_i,
    input  logic                    instr_ready_i,
    output logic                    instr_valid_o,
    output logic [31:0]             instr_o,
    output logic [`ADDR_SIZE-1:0]   instr_pc_o,
    output logic                    instr_fault_o,
    fetch_if.ctrl                   fetch
);
    import fetch_pkg::*;

    fetch_addr_u pc_q;
    logic        halted_q;
    logic        accept;

    // Core takes the instruction this cycle
    assign accept = instr_valid_o & instr_ready_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q     <= `RESET_PC;
            halted_q <= 1'b0;
        end else if (redirect_valid_i) begin
            // Redirect wins over a step and leaves a fault halt
            pc_q     <= redirect_pc_i;
            halted_q <= 1'b0;
        end else if (accept) begin
            pc_q     <= pc_q + `ADDR_SIZE'd4;
            // Stop after handing over a faulting fetch
            halted_q <= fetch.resp_fault;
        end
    end

    // No request in a redirect or flush cycle, so the old path never shows
    assign fetch.req_valid         = ~halted_q & ~redirect_valid_i & ~flush_i;
    assign fetch.vaddr             = pc_q;
    assign fetch.inval_fetch       = redirect_valid_i;
    // Flush drops both the line buffer and the cache
    assign fetch.invalidate_buffer = flush_i;
    assign fetch.invalidate_icache = flush_i;

    // Response goes straight out
    assign instr_valid_o = fetch.resp_valid;
    assign instr_o       = fetch.resp_data;
    assign instr_fault_o = fetch.resp_fault;
    assign instr_pc_o    = pc_q;

endmodule

// File: hdl/icache_interface.sv
// Fetch line buffer and cache request FSM
`include "fetch_macros.svh"

module icache_interface (
    input  logic   clk_i,
    input  logic   rstn_i,
    fetch_if.lbuf  fetch,
    icache_if.req  cache
);
    import fetch_pkg::*;

    // Request FSM states
    localparam logic NoReq    = 1'b0;
    localparam logic ReqValid = 1'b1;

    logic                      state_q;
    logic                      state_d;
    logic [`LINE_BITS-1:0]     buf_line_q;
    logic [LINE_ADDR_BITS-1:0] buf_tag_q;
    logic                      buf_valid_q;
    fetch_addr_u               req_addr_q;
    logic [`LINE_BITS-1:0]     line_sel;
    logic                      buf_hit;
    logic                      new_addr;
    logic                      resp_match;
    logic                      resp_ok;
    logic                      do_request;
    logic                      kill;
    logic                      load_buf;

    // Buffered line covers the current PC
    assign buf_hit = buf_valid_q & (buf_tag_q == fetch.vaddr.line_view.line);

    // PC moved to another line since the request went out
    assign new_addr = req_addr_q.line_view.line != fetch.vaddr.line_view.line;

    // Cache answer belongs to the line being fetched now
    assign resp_match = cache.resp_valid &
                        (cache.resp_vaddr.line_view.line == fetch.vaddr.line_view.line);
    assign resp_ok    = (state_q == ReqValid) & fetch.req_valid & resp_match;

    // Issue only from NoReq and only on a buffer miss
    assign do_request = (state_q == NoReq) & fetch.req_valid & ~buf_hit &
                        ~fetch.inval_fetch & ~fetch.invalidate_buffer & cache.req_ready;

    // Drop an outstanding request when the fetch goes elsewhere
    assign kill = (state_q == ReqValid) &
                  (new_addr | ~fetch.req_valid | fetch.inval_fetch | fetch.invalidate_buffer);

    // Faulting lines never enter the buffer
    assign load_buf = resp_ok & ~cache.resp_xcpt & ~fetch.invalidate_buffer;

    always_comb begin
        case (state_q)
            NoReq: begin
                state_d = do_request ? ReqValid : NoReq;
            end
            ReqValid: begin
                // Back to idle on the answer or on a kill
                state_d = (resp_ok | kill) ? NoReq : ReqValid;
            end
            default: begin
                state_d = NoReq;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q     <= NoReq;
            buf_valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (fetch.invalidate_buffer) begin
                buf_valid_q <= 1'b0;
            end else if (load_buf) begin
                buf_valid_q <= 1'b1;
            end
        end
    end

    // Line data, its address and the issued address
    always_ff @(posedge clk_i) begin
        if (load_buf) begin
            buf_line_q <= cache.resp_line;
            buf_tag_q  <= cache.resp_vaddr.line_view.line;
        end
        if (do_request) begin
            req_addr_q <= fetch.vaddr;
        end
    end

    // Cache side
    assign cache.req_valid  = do_request;
    assign cache.vpn        = fetch.vaddr.page_view.vpn;
    assign cache.idx        = fetch.vaddr.page_view.idx;
    assign cache.kill       = kill;
    assign cache.invalidate = fetch.invalidate_icache;

    // Hit answers from the buffer, miss forwards the fresh line in the same cycle
    assign fetch.resp_valid = fetch.req_valid & (buf_hit | resp_ok);
    assign fetch.resp_fault = resp_ok & ~buf_hit & cache.resp_xcpt;
    assign line_sel         = buf_hit ? buf_line_q : cache.resp_line;

    // Word select, zero on a fault
    always_comb begin
        if (fetch.resp_fault) begin
            fetch.resp_data = 32'h0;
        end else begin
            case (fetch.vaddr.line_view.word)
                2'd0:    fetch.resp_data = line_sel[31:0];
                2'd1:    fetch.resp_data = line_sel[63:32];
                2'd2:    fetch.resp_data = line_sel[95:64];
                default: fetch.resp_data = line_sel[127:96];
            endcase
        end
    end

endmodule

// File: hdl/icache.sv
// Direct-mapped instruction cache
`include "fetch_macros.svh"

module icache (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    icache_if.rsp                 cache,
    output logic                  wb_cyc_o,
    output logic                  wb_stb_o,
    output logic [`ADDR_SIZE-1:0] wb_adr_o,
    input  logic [31:0]           wb_dat_i,
    input  logic                  wb_ack_i
);
    import fetch_pkg::*;

    localparam int SET_BITS = $clog2(`ICACHE_LINES);
    localparam int TAG_BITS = LINE_ADDR_BITS - SET_BITS;

    // Cache FSM states
    localparam logic [1:0] IDLE = 2'd0;
    localparam logic [1:0] FILL = 2'd1;
    localparam logic [1:0] RESP = 2'd2;

    logic [`LINE_BITS-1:0] data_q [`ICACHE_LINES];
    logic [TAG_BITS-1:0]   tag_q  [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0] valid_q;
    logic [1:0]            state_q;
    logic [1:0]            word_q;
    logic                  xcpt_q;
    logic                  killed_q;
    fetch_addr_u           addr_q;
    fetch_addr_u           req_addr;
    logic [SET_BITS-1:0]   req_set;
    logic [TAG_BITS-1:0]   req_tag;
    logic [SET_BITS-1:0]   set_q;
    logic                  req_fire;
    logic                  req_hit;
    logic                  req_fault;
    logic                  last_ack;

    // Rebuild the address from its page view, index and tag from the line view
    assign req_addr = {cache.vpn, cache.idx};
    assign req_set  = req_addr.line_view.line[SET_BITS-1:0];
    assign req_tag  = req_addr.line_view.line[LINE_ADDR_BITS-1:SET_BITS];
    assign set_q    = addr_q.line_view.line[SET_BITS-1:0];

    assign req_fire  = cache.req_valid & cache.req_ready;
    // Unmapped page, answered without touching the bus
    assign req_fault = cache.vpn >= VPN_BITS'(`MEM_PAGES);
    assign req_hit   = valid_q[req_set] & (tag_q[req_set] == req_tag);
    assign last_ack  = (state_q == FILL) & wb_ack_i & (word_q == 2'd3);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q  <= IDLE;
            word_q   <= 2'd0;
            xcpt_q   <= 1'b0;
            killed_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (req_fire) begin
                        killed_q <= 1'b0;
                        xcpt_q   <= req_fault;
                        word_q   <= 2'd0;
                        state_q  <= (req_fault | req_hit) ? RESP : FILL;
                    end
                end
                FILL: begin
                    // A killed fill still completes, only the answer is dropped
                    if (cache.kill) begin
                        killed_q <= 1'b1;
                    end
                    if (wb_ack_i) begin
                        word_q <= word_q + 2'd1;
                        if (word_q == 2'd3) begin
                            state_q <= RESP;
                        end
                    end
                end
                RESP: begin
                    state_q <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Request address, line words and tags
    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            addr_q <= req_addr;
        end
        if ((state_q == FILL) && wb_ack_i) begin
            data_q[set_q][{word_q, 5'd0} +: 32] <= wb_dat_i;
        end
        if (last_ack) begin
            tag_q[set_q] <= addr_q.line_view.line[LINE_ADDR_BITS-1:SET_BITS];
        end
    end

    // Valid bits, flush has priority over a fill finishing
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= '0;
        end else if (cache.invalidate) begin
            valid_q <= '0;
        end else if (req_fire && !req_fault && !req_hit) begin
            // Line is overwritten word by word, so it stops being valid now
            valid_q[req_set] <= 1'b0;
        end else if (last_ack) begin
            valid_q[set_q] <= 1'b1;
        end
    end

    // Wishbone classic read, strobe held until each ack, lowest word first
    assign wb_cyc_o = (state_q == FILL);
    assign wb_stb_o = (state_q == FILL);
    assign wb_adr_o = {addr_q.line_view.line, word_q, 2'b00};

    // Response one cycle after a hit, a fault or the last ack
    assign cache.req_ready  = (state_q == IDLE);
    assign cache.resp_valid = (state_q == RESP) & ~killed_q;
    assign cache.resp_vaddr = addr_q;
    assign cache.resp_line  = data_q[set_q];
    assign cache.resp_xcpt  = xcpt_q;

endmodule

// File: hdl/fetch_top.sv
// Instruction fetch front end
`include "fetch_macros.svh"

module fetch_top (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  redirect_valid_i,
    input  logic [`ADDR_SIZE-1:0] redirect_pc_i,
    input  logic                  flush_i,
    input  logic                  instr_ready_i,
    output logic                  instr_valid_o,
    output logic [31:0]           instr_o,
    output logic [`ADDR_SIZE-1:0] instr_pc_o,
    output logic                  instr_fault_o,
    output logic                  wb_cyc_o,
    output logic                  wb_stb_o,
    output logic [`ADDR_SIZE-1:0] wb_adr_o,
    input  logic [31:0]           wb_dat_i,
    input  logic                  wb_ack_i
);

    // PC sequencer to line buffer
    fetch_if  u_fetch_if ();
    // Line buffer to cache
    icache_if u_icache_if ();

    fetch_ctrl u_fetch_ctrl (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .flush_i          (flush_i),
        .instr_ready_i    (instr_ready_i),
        .instr_valid_o    (instr_valid_o),
        .instr_o          (instr_o),
        .instr_pc_o       (instr_pc_o),
        .instr_fault_o    (instr_fault_o),
        .fetch            (u_fetch_if.ctrl)
    );

    icache_interface u_icache_interface (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .fetch  (u_fetch_if.lbuf),
        .cache  (u_icache_if.req)
    );

    // Line fills over the Wishbone ports
    icache u_icache (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .cache    (u_icache_if.rsp),
        .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o),
        .wb_adr_o (wb_adr_o),
        .wb_dat_i (wb_dat_i),
        .wb_ack_i (wb_ack_i)
    );

endmodule

// File: bench/fetch_chk.sv
// Fetch front end port assertions
module fetch_chk (
    input logic        clk_i,
    input logic        rstn_i,
    input logic        wb_cyc_o,
    input logic        wb_stb_o,
    input logic [31:0] wb_adr_o,
    input logic        wb_ack_i,
    input logic        instr_valid_o,
    input logic        instr_fault_o,
    input logic [31:0] instr_o
);

    // Strobe and cycle stay up through each wait state
    stb_held: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (wb_stb_o && !wb_ack_i) |=> (wb_stb_o && wb_cyc_o))
        else $error("wishbone strobe or cycle dropped before ack");

    // Address held while a transfer waits for its ack
    adr_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (wb_stb_o && !wb_ack_i) |=> $stable(wb_adr_o))
        else $error("wishbone address moved during wait state");

    // Faulting fetch carries no data
    fault_zero: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (instr_valid_o && instr_fault_o) |-> (instr_o == 32'h0))
        else $error("faulting instruction with nonzero data");

    // Nothing delivered in the first cycle out of reset
    quiet_after_reset: assert property (@(posedge clk_i)
        $rose(rstn_i) |-> !instr_valid_o)
        else $error("instruction valid right after reset");

endmodule

bind fetch_top fetch_chk u_fetch_chk (.*);

// File: bench/fetch_tb.sv
// Fetch front end testbench
`include "fetch_macros.svh"

module fetch_tb;

    localparam logic [31:0] MEM_KEY = 32'h5a5a_0f0f;
    localparam int OP_RUN = 0;
    localparam int OP_REDIR = 1;
    localparam int OP_FLUSH = 2;
    localparam int OP_BP = 3;

    logic        clk_i;
    logic        rstn_i;
    logic        redirect_valid_i;
    logic [31:0] redirect_pc_i;
    logic        flush_i;
    logic        instr_ready_i;
    logic        instr_valid_o;
    logic [31:0] instr_o;
    logic [31:0] instr_pc_o;
    logic        instr_fault_o;
    logic        wb_cyc_o;
    logic        wb_stb_o;
    logic [31:0] wb_adr_o;
    logic [31:0] wb_dat_i;
    logic        wb_ack_i;

    integer bp_seed = 32'hcd20a046;
    integer mem_seed = 32'hcd20a046;
    int     errors = 0;
    int     checks = 0;
    int     xfer_count = 0;
    int     wait_left = 0;
    // Stimulus table columns are op, target PC, instructions, fault flag and bus transfers
    int     op_t[$];
    int     pc_t[$];
    int     n_t[$];
    int     fault_t[$];
    int     xfer_t[$];

    fetch_top u_fetch_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // Wishbone memory model with 0 to 3 wait states per transfer
    // Each word is its own address XOR a key
    always @(negedge clk_i) begin
        if (wb_cyc_o && wb_stb_o) begin
            if (wait_left == 0) begin
                wb_ack_i   = 1'b1;
                wb_dat_i   = wb_adr_o ^ MEM_KEY;
                xfer_count = xfer_count + 1;
                wait_left  = $random(mem_seed) & 3;
            end else begin
                wb_ack_i  = 1'b0;
                wait_left = wait_left - 1;
            end
        end else begin
            wb_ack_i = 1'b0;
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic add_entry(input int op, input int pc, input int n, input int fault,
                             input int xfers);
        op_t.push_back(op);
        pc_t.push_back(pc);
        n_t.push_back(n);
        fault_t.push_back(fault);
        xfer_t.push_back(xfers);
    endtask

    // Unmapped pages give zero data and a fault
    function automatic logic mem_fault(input logic [31:0] pc);
        return pc[31:12] >= `MEM_PAGES;
    endfunction

    task automatic run_instrs(input int n, input logic [31:0] first_pc, input bit bp,
                              input bit idle_after, output int got, output bit last_fault);
        logic [31:0] exp_pc;
        logic        hold;
        logic [31:0] held_instr;
        got = 0;
        last_fault = 1'b0;
        exp_pc = first_pc;
        hold = 1'b0;
        held_instr = '0;
        while (got < n) begin
            // Random stall pattern only for back-pressure entries
            instr_ready_i = bp ? 1'($random(bp_seed)) : 1'b1;
            #2;
            // Stalled outputs must not move or drop
            if (hold) begin
                check_value("held valid", instr_valid_o, 1'b1);
                check_value("held instr", instr_o, held_instr);
                check_value("held pc", instr_pc_o, exp_pc);
            end
            if (instr_valid_o && instr_ready_i) begin
                check_value("pc", instr_pc_o, exp_pc);
                check_value("instr", instr_o, mem_fault(exp_pc) ? 32'h0 : exp_pc ^ MEM_KEY);
                check_value("fault", instr_fault_o, mem_fault(exp_pc));
                last_fault = instr_fault_o;
                exp_pc += 4;
                got++;
            end
            hold = instr_valid_o & ~instr_ready_i;
            held_instr = instr_o;
            @(negedge clk_i);
        end
        // After a fault nothing more may come out
        if (idle_after) begin
            repeat (20) begin
                instr_ready_i = 1'b1;
                #2;
                if (instr_valid_o) begin
                    got++;
                end
                @(negedge clk_i);
            end
        end
    endtask

    // Limit from total instructions times a worst case line fill
    initial begin
        int total;
        #1;
        total = 0;
        foreach (n_t[i]) begin
            total += n_t[i] + 30;
        end
        #(total * 48 * 8 + 16 * 8);
        $display("Watchdog expired before the stimulus table finished");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int  got;
        int  start;
        bit  fault;
        rstn_i = 1'b0;
        redirect_valid_i = 1'b0;
        redirect_pc_i = '0;
        flush_i = 1'b0;
        instr_ready_i = 1'b0;
        wb_dat_i = '0;
        wb_ack_i = 1'b0;
        // Cold run over four lines
        add_entry(OP_RUN, 32'h0000, 14, 0, 16);
        // Ends on a line edge so the next line miss is in flight
        add_entry(OP_RUN, 32'h0038, 2, 0, 0);
        // Killed fill still costs its four transfers
        add_entry(OP_REDIR, 32'h0180, 6, 0, 12);
        add_entry(OP_REDIR, 32'h0000, 15, 0, 0);
        // Crosses into the first unmapped page
        add_entry(OP_REDIR, 32'h3ff8, 3, 1, 4);
        add_entry(OP_FLUSH, 32'h0000, 3, 0, 4);
        add_entry(OP_BP, 32'h000c, 24, 0, 24);
        add_entry(OP_REDIR, 32'h0020, 5, 0, 0);
        repeat (16) @(negedge clk_i);
        rstn_i = 1'b1;
        foreach (op_t[i]) begin
            start = xfer_count;
            if (op_t[i] == OP_REDIR || op_t[i] == OP_FLUSH) begin
                instr_ready_i = 1'b0;
                repeat (2) @(negedge clk_i);
                if (op_t[i] == OP_FLUSH) begin
                    flush_i = 1'b1;
                    @(negedge clk_i);
                    flush_i = 1'b0;
                end
                redirect_valid_i = 1'b1;
                redirect_pc_i = pc_t[i];
                @(negedge clk_i);
                redirect_valid_i = 1'b0;
            end
            run_instrs(n_t[i], pc_t[i], op_t[i] == OP_BP, fault_t[i] != 0, got, fault);
            check_value("instr count", got, n_t[i]);
            check_value("fault flag", fault, fault_t[i]);
            check_value("wishbone transfers", xfer_count - start, xfer_t[i]);
        end
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+hdl
hdl/fetch_pkg.sv
hdl/fetch_if.sv
hdl/fetch_ctrl.sv
hdl/icache_interface.sv
hdl/icache.sv
hdl/fetch_top.sv
bench/fetch_chk.sv
bench/fetch_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then look for the failure line in the log
rm -f sim.log build.log
verilator --binary --timing --assert -Wno-fatal -Ihdl --top-module fetch_tb \
    -f verilog.f -o fetch_sim > build.log 2>&1 \
    && ./obj_dir/fetch_sim > sim.log 2>&1 \
    || echo "TEST FAILED" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
